/* rtl/ooo_pkg.sv */
`default_nettype none

// shared sizes and alu function codes for the out-of-order execution slice
package ooo_pkg;

    // architectural register space
    localparam int REG_ADDR_LEN = 5;   // five address bits select one of 32 registers
    localparam int REG_NUM      = 32;  // register 0 is hardwired to zero
    localparam int DATA_WIDTH   = 32;  // register and result width

    // function code width, eight codes fill the whole space
    localparam int FUNC_WIDTH = 3;

    // arithmetic
    localparam logic [FUNC_WIDTH-1:0] ALU_ADD = 3'd0;  // a + b
    localparam logic [FUNC_WIDTH-1:0] ALU_SUB = 3'd1;  // a - b

    // bitwise logic
    localparam logic [FUNC_WIDTH-1:0] ALU_AND = 3'd2;
    localparam logic [FUNC_WIDTH-1:0] ALU_OR  = 3'd3;
    localparam logic [FUNC_WIDTH-1:0] ALU_XOR = 3'd4;

    // shifts take their amount from the low five bits of the second operand
    localparam logic [FUNC_WIDTH-1:0] ALU_SLL = 3'd5;  // logical left
    localparam logic [FUNC_WIDTH-1:0] ALU_SRL = 3'd6;  // logical right, zero fill

    // signed set-less-than gives 1 or 0
    localparam logic [FUNC_WIDTH-1:0] ALU_SLT = 3'd7;

endpackage

`default_nettype wire

/* rtl/dispatch_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

// in-order instruction fifo in front of the issue queue
// the head is popped into registered load outputs, one instruction per load pulse
module dispatch_buffer import ooo_pkg::*; #(
    parameter int FIFO_DEPTH = 4
) (
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     disp_valid,
    input  wire  [FUNC_WIDTH-1:0]   func,
    input  wire  [REG_ADDR_LEN-1:0] dst,
    input  wire  [REG_ADDR_LEN-1:0] inp1,
    input  wire  [REG_ADDR_LEN-1:0] inp2,
    input  wire                     is_full,
    output logic                    disp_full,
    output logic                    load,
    output logic [FUNC_WIDTH-1:0]   load_func,
    output logic [REG_ADDR_LEN-1:0] load_dst,
    output logic [REG_ADDR_LEN-1:0] load_inp1,
    output logic [REG_ADDR_LEN-1:0] load_inp2
);
    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);  // count must reach FIFO_DEPTH itself

    logic [FUNC_WIDTH-1:0]   func_mem [FIFO_DEPTH];
    logic [REG_ADDR_LEN-1:0] dst_mem  [FIFO_DEPTH];
    logic [REG_ADDR_LEN-1:0] inp1_mem [FIFO_DEPTH];
    logic [REG_ADDR_LEN-1:0] inp2_mem [FIFO_DEPTH];
    logic [PTR_W-1:0]        rd_ptr;
    logic [PTR_W-1:0]        wr_ptr;
    logic [CNT_W-1:0]        count;
    logic                    push;
    logic                    pop;

    // pointers wrap at FIFO_DEPTH so a depth that is not a power of two also works
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign disp_full = (count == CNT_W'(FIFO_DEPTH));
    assign push      = disp_valid && !disp_full;  // source holds and retries while full
    // a load still in flight is not yet counted in is_full, so wait for it to land
    assign pop       = (count != '0) && !is_full && !load;

    always_ff @(posedge clk) begin
        if (push) begin
            func_mem[wr_ptr] <= func;
            dst_mem[wr_ptr]  <= dst;
            inp1_mem[wr_ptr] <= inp1;
            inp2_mem[wr_ptr] <= inp2;
        end
        if (pop) begin  // head fields are held until the next pop
            load_func <= func_mem[rd_ptr];
            load_dst  <= dst_mem[rd_ptr];
            load_inp1 <= inp1_mem[rd_ptr];
            load_inp2 <= inp2_mem[rd_ptr];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
            load   <= 1'b0;
        end else begin
            load <= pop;  // one cycle pulse per popped instruction
            if (push) wr_ptr <= next_ptr(wr_ptr);
            if (pop) rd_ptr <= next_ptr(rd_ptr);
            count <= count + CNT_W'(push) - CNT_W'(pop);
        end
    end

endmodule

`default_nettype wire

/* rtl/age_select.sv */
`timescale 1ns/1ps
`default_nettype none

// oldest-ready picker for the issue queue
// a smaller age rank means an older entry, and ranks of valid entries never repeat
module age_select #(
    parameter  int NUM_ENTRIES = 4,
    localparam int AGE_W       = (NUM_ENTRIES > 1) ? $clog2(NUM_ENTRIES) : 1,
    localparam int IDX_W       = AGE_W  // one slot per rank, so index and rank share a width
) (
    input  wire  [NUM_ENTRIES-1:0]       ready_flags,  // valid and both sources ready
    input  wire  [NUM_ENTRIES*AGE_W-1:0] ages,         // rank of entry i at bits i*AGE_W
    output logic                         exist_ready,
    output logic [IDX_W-1:0]             sel_idx,
    output logic [AGE_W-1:0]             sel_age
);

    // linear scan over all slots
    // the first ready entry is always taken, later ones only if strictly older
    always_comb begin
        exist_ready = 1'b0;
        sel_idx     = '0;
        sel_age     = '0;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (ready_flags[i] && (!exist_ready || (ages[i*AGE_W +: AGE_W] < sel_age))) begin
                exist_ready = 1'b1;
                sel_idx     = IDX_W'(i);
                sel_age     = ages[i*AGE_W +: AGE_W];  // queue uses this to shift younger ranks
            end
        end
    end

    // with no ready entry the index and rank stay zero and exist_ready stays low,
    // the queue then neither issues nor frees a slot

endmodule

`default_nettype wire

/* rtl/issue_queue.sv */
`timescale 1ns/1ps
`default_nettype none

// reservation station for register-to-register alu instructions
// sources take their readiness from a per-register ready table at load time,
// and the destination of an issued entry wakes its dependants at the same edge
module issue_queue import ooo_pkg::*; #(
    parameter int NUM_ENTRIES = 4
) (
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     load,      // one instruction from dispatch, never while full
    input  wire                     issue,     // level request to send the oldest ready entry
    input  wire  [FUNC_WIDTH-1:0]   insn,
    input  wire  [REG_ADDR_LEN-1:0] inp1,
    input  wire  [REG_ADDR_LEN-1:0] inp2,
    input  wire  [REG_ADDR_LEN-1:0] dst,
    output logic                    issue_ready,  // outputs below are valid for this cycle
    output logic                    is_full,
    output logic [FUNC_WIDTH-1:0]   insn_out,
    output logic [REG_ADDR_LEN-1:0] inp1_out,
    output logic [REG_ADDR_LEN-1:0] inp2_out,
    output logic [REG_ADDR_LEN-1:0] dst_out
);
    localparam int AGE_W = (NUM_ENTRIES > 1) ? $clog2(NUM_ENTRIES) : 1;
    localparam int CNT_W = $clog2(NUM_ENTRIES + 1);

    // entry state, one bit or field per slot
    logic [NUM_ENTRIES-1:0]  valid;
    logic [NUM_ENTRIES-1:0]  ready1;
    logic [NUM_ENTRIES-1:0]  ready2;
    logic [FUNC_WIDTH-1:0]   func_q [NUM_ENTRIES];
    logic [REG_ADDR_LEN-1:0] src1_q [NUM_ENTRIES];
    logic [REG_ADDR_LEN-1:0] src2_q [NUM_ENTRIES];
    logic [REG_ADDR_LEN-1:0] dst_q  [NUM_ENTRIES];
    logic [AGE_W-1:0]        age_q  [NUM_ENTRIES];  // 0 is the oldest valid entry
    logic [REG_NUM-1:0]      ready_table;           // bit r low while a writer of r is queued

    logic [CNT_W-1:0]             occupancy;
    logic [AGE_W-1:0]             free_idx;
    logic [AGE_W-1:0]             new_age;
    logic [NUM_ENTRIES-1:0]       ready_flags;
    logic [NUM_ENTRIES*AGE_W-1:0] ages_flat;
    logic                         exist_ready;
    logic [AGE_W-1:0]             sel_idx;
    logic [AGE_W-1:0]             sel_age;
    logic                         do_issue;
    logic [REG_ADDR_LEN-1:0]      iss_dst;
    logic                         new_ready1;
    logic                         new_ready2;

    // occupancy count and lowest free slot
    // scanning downward leaves the lowest free index as the last one written
    always_comb begin
        occupancy = '0;
        free_idx  = '0;
        for (int i = NUM_ENTRIES - 1; i >= 0; i--) begin
            occupancy = occupancy + CNT_W'(valid[i]);
            if (!valid[i]) free_idx = AGE_W'(i);
        end
    end

    assign is_full = (occupancy == CNT_W'(NUM_ENTRIES));

    always_comb begin
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            ready_flags[i]               = valid[i] && ready1[i] && ready2[i];
            ages_flat[i*AGE_W +: AGE_W]  = age_q[i];
        end
    end

    age_select #(
        .NUM_ENTRIES (NUM_ENTRIES)
    ) age_select_i (
        .ready_flags (ready_flags),
        .ages        (ages_flat),
        .exist_ready (exist_ready),
        .sel_idx     (sel_idx),
        .sel_age     (sel_age)
    );

    assign do_issue = issue && exist_ready;
    assign iss_dst  = dst_q[sel_idx];

    // a new entry is the youngest, its rank drops by one if an older one leaves now
    assign new_age = do_issue ? AGE_W'(occupancy - 1'b1) : AGE_W'(occupancy);

    // bypass the wakeup of this edge, otherwise a consumer loaded together with
    // its producer's issue would miss the ready table update and never wake
    assign new_ready1 = ready_table[inp1] || (do_issue && (iss_dst == inp1));
    assign new_ready2 = ready_table[inp2] || (do_issue && (iss_dst == inp2));

    always_ff @(posedge clk) begin
        if (reset) begin
            valid       <= '0;
            ready1      <= '0;
            ready2      <= '0;
            ready_table <= '1;  // nothing in flight, every register readable
            issue_ready <= 1'b0;
            for (int i = 0; i < NUM_ENTRIES; i++) begin
                age_q[i] <= '0;
            end
        end else begin
            issue_ready <= do_issue;
            if (do_issue) begin
                valid[sel_idx]       <= 1'b0;
                ready_table[iss_dst] <= 1'b1;  // result is written back one cycle later
                for (int i = 0; i < NUM_ENTRIES; i++) begin
                    if (valid[i] && (age_q[i] > sel_age)) age_q[i] <= age_q[i] - 1'b1;
                    // both sources are checked, an entry may read the same register twice
                    if (valid[i] && (src1_q[i] == iss_dst)) ready1[i] <= 1'b1;
                    if (valid[i] && (src2_q[i] == iss_dst)) ready2[i] <= 1'b1;
                end
            end
            if (load) begin  // the free slot differs from the issued one, both may happen
                valid[free_idx]  <= 1'b1;
                ready1[free_idx] <= new_ready1;
                ready2[free_idx] <= new_ready2;
                age_q[free_idx]  <= new_age;
                ready_table[dst] <= (dst == '0);  // register 0 never waits on a writer
            end
        end
    end

    // instruction fields and issue outputs
    always_ff @(posedge clk) begin
        if (load) begin
            func_q[free_idx] <= insn;
            src1_q[free_idx] <= inp1;
            src2_q[free_idx] <= inp2;
            dst_q[free_idx]  <= dst;
        end
        if (do_issue) begin
            insn_out <= func_q[sel_idx];
            inp1_out <= src1_q[sel_idx];
            inp2_out <= src2_q[sel_idx];
            dst_out  <= iss_dst;
        end
    end

endmodule

`default_nettype wire

/* rtl/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

// architectural register file, two combinational reads and one write
// reads see the old value during the write cycle and the new one after the edge
module reg_file import ooo_pkg::*; (
    input  wire                     clk,
    input  wire                     reset,
    input  wire  [REG_ADDR_LEN-1:0] rd_addr1,
    input  wire  [REG_ADDR_LEN-1:0] rd_addr2,
    input  wire                     wr_en,
    input  wire  [REG_ADDR_LEN-1:0] wr_addr,
    input  wire  [DATA_WIDTH-1:0]   wr_data,
    output logic [DATA_WIDTH-1:0]   rd_data1,
    output logic [DATA_WIDTH-1:0]   rd_data2
);

    logic [DATA_WIDTH-1:0] regs [REG_NUM];

    // start state is register r holding r, so register 0 starts at zero too
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < REG_NUM; i++) begin
                regs[i] <= DATA_WIDTH'(i);
            end
        end else if (wr_en && (wr_addr != '0)) begin
            regs[wr_addr] <= wr_data;  // writes to register 0 are dropped
        end
    end

    // register 0 reads zero because it is reset to zero and never written
    assign rd_data1 = regs[rd_addr1];
    assign rd_data2 = regs[rd_addr2];

    // no write-to-read bypass is needed
    // a consumer issues at the earliest one edge after its producer left the
    // queue, and by then the producer's write-back edge has passed

endmodule

`default_nettype wire

/* rtl/alu_exec.sv */
`timescale 1ns/1ps
`default_nettype none

// single-cycle integer alu
// computes during the issue_ready cycle, writes back at the next edge and
// reports the same result on the registered result outputs
module alu_exec import ooo_pkg::*; (
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     issue_ready,  // func, dst and operands valid this cycle
    input  wire  [FUNC_WIDTH-1:0]   func,
    input  wire  [REG_ADDR_LEN-1:0] dst,
    input  wire  [DATA_WIDTH-1:0]   opa,
    input  wire  [DATA_WIDTH-1:0]   opb,
    output logic                    wr_en,
    output logic [REG_ADDR_LEN-1:0] wr_addr,
    output logic [DATA_WIDTH-1:0]   wr_data,
    output logic                    result_valid,
    output logic [REG_ADDR_LEN-1:0] result_dst,
    output logic [DATA_WIDTH-1:0]   result_data
);
    localparam int SHAMT_W = $clog2(DATA_WIDTH);  // five bits for a 32-bit datapath

    logic [DATA_WIDTH-1:0] alu_out;
    logic [SHAMT_W-1:0]    shamt;

    assign shamt = opb[SHAMT_W-1:0];

    always_comb begin
        case (func)
            ALU_ADD: alu_out = opa + opb;
            ALU_SUB: alu_out = opa - opb;
            ALU_AND: alu_out = opa & opb;
            ALU_OR:  alu_out = opa | opb;
            ALU_XOR: alu_out = opa ^ opb;
            ALU_SLL: alu_out = opa << shamt;
            ALU_SRL: alu_out = opa >> shamt;  // logical, zeros shifted in
            ALU_SLT: alu_out = ($signed(opa) < $signed(opb)) ? DATA_WIDTH'(1) : '0;
            default: alu_out = '0;
        endcase
    end

    // write-back is driven straight from the issue cycle
    assign wr_en   = issue_ready;
    assign wr_addr = dst;
    assign wr_data = alu_out;

    always_ff @(posedge clk) begin
        if (reset) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= issue_ready;  // lands at the same edge as the register write
        end
    end

    always_ff @(posedge clk) begin
        if (issue_ready) begin
            result_dst  <= dst;
            result_data <= alu_out;  // a write to register 0 is still reported as computed
        end
    end

endmodule

`default_nettype wire

/* rtl/ooo_core.sv */
`timescale 1ns/1ps
`default_nettype none

// execution slice top: dispatch buffer, issue queue, register file and alu
module ooo_core import ooo_pkg::*; #(
    parameter int NUM_ENTRIES = 4,  // issue queue depth
    parameter int FIFO_DEPTH  = 4   // dispatch buffer depth
) (
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     disp_valid,
    input  wire  [FUNC_WIDTH-1:0]   func,
    input  wire  [REG_ADDR_LEN-1:0] dst,
    input  wire  [REG_ADDR_LEN-1:0] inp1,
    input  wire  [REG_ADDR_LEN-1:0] inp2,
    input  wire                     issue,
    output logic                    disp_full,
    output logic                    result_valid,
    output logic [REG_ADDR_LEN-1:0] result_dst,
    output logic [DATA_WIDTH-1:0]   result_data
);
    // dispatch to queue
    logic                    load;
    logic                    is_full;
    logic [FUNC_WIDTH-1:0]   load_func;
    logic [REG_ADDR_LEN-1:0] load_dst, load_inp1, load_inp2;
    // queue to register file and alu
    logic                    issue_ready;
    logic [FUNC_WIDTH-1:0]   insn_out;
    logic [REG_ADDR_LEN-1:0] inp1_out, inp2_out, dst_out;
    // operands and write-back
    logic [DATA_WIDTH-1:0]   rd_data1, rd_data2;
    logic                    wr_en;
    logic [REG_ADDR_LEN-1:0] wr_addr;
    logic [DATA_WIDTH-1:0]   wr_data;

    dispatch_buffer #(.FIFO_DEPTH(FIFO_DEPTH)) dispatch_buffer_i (
        .clk(clk), .reset(reset), .disp_valid(disp_valid), .func(func), .dst(dst),
        .inp1(inp1), .inp2(inp2), .is_full(is_full), .disp_full(disp_full), .load(load),
        .load_func(load_func), .load_dst(load_dst), .load_inp1(load_inp1),
        .load_inp2(load_inp2)
    );

    issue_queue #(.NUM_ENTRIES(NUM_ENTRIES)) issue_queue_i (
        .clk(clk), .reset(reset), .load(load), .issue(issue), .insn(load_func),
        .inp1(load_inp1), .inp2(load_inp2), .dst(load_dst), .issue_ready(issue_ready),
        .is_full(is_full), .insn_out(insn_out), .inp1_out(inp1_out), .inp2_out(inp2_out),
        .dst_out(dst_out)
    );

    reg_file reg_file_i (
        .clk(clk), .reset(reset), .rd_addr1(inp1_out), .rd_addr2(inp2_out), .wr_en(wr_en),
        .wr_addr(wr_addr), .wr_data(wr_data), .rd_data1(rd_data1), .rd_data2(rd_data2)
    );

    alu_exec alu_exec_i (
        .clk(clk), .reset(reset), .issue_ready(issue_ready), .func(insn_out), .dst(dst_out),
        .opa(rd_data1), .opb(rd_data2), .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
        .result_valid(result_valid), .result_dst(result_dst), .result_data(result_data)
    );

endmodule

`default_nettype wire

/* tb/ooo_core_props.sv */
`timescale 1ns/1ps
`default_nettype none

// protocol checks on the issue queue ports, bound into every issue_queue instance
module ooo_core_props (
    input wire clk,
    input wire reset,
    input wire load,
    input wire issue,
    input wire is_full,
    input wire issue_ready
);
    int fail_count = 0;  // the testbench reads this through the bound instance

    // dispatch holds its load back while the queue has no free slot
    load_not_full: assert property (@(posedge clk) disable iff (reset) !(load && is_full))
        else begin
            fail_count++;
            $error("load strobe while the issue queue is full");
        end

    // an issued entry only ever answers a request seen on the edge before
    ready_after_issue: assert property (@(posedge clk) disable iff (reset)
        issue_ready |-> $past(issue))
        else begin
            fail_count++;
            $error("issue_ready without an issue request on the previous edge");
        end

    // a reset edge leaves both strobes of the queue low
    quiet_in_reset: assert property (@(posedge clk) reset |=> (!issue_ready && !load))
        else begin
            fail_count++;
            $error("queue strobe high after a reset edge");
        end
endmodule

bind issue_queue ooo_core_props ooo_core_props_i (
    .clk(clk), .reset(reset), .load(load), .issue(issue), .is_full(is_full),
    .issue_ready(issue_ready)
);

`default_nettype wire

/* tb/ooo_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

// shadow register model predicts each result at dispatch, results are checked at the falling edge
module ooo_core_tb import ooo_pkg::*; ();
    localparam int LIMIT    = 400;  // longest any single wait may last, in cycles
    localparam int CAPACITY = 8;    // four buffer slots plus four queue entries

    logic                    clk = 1'b0;
    logic                    reset = 1'b1;
    logic                    disp_valid = 1'b0;
    logic                    issue = 1'b0;
    logic [FUNC_WIDTH-1:0]   func = '0;
    logic [REG_ADDR_LEN-1:0] dst = '0, inp1 = '0, inp2 = '0;
    logic                    disp_full, result_valid;
    logic [REG_ADDR_LEN-1:0] result_dst;
    logic [DATA_WIDTH-1:0]   result_data;

    logic [31:0]             lfsr_state = 32'h49d81521;
    logic [DATA_WIDTH-1:0]   shadow [REG_NUM];   // architectural values in program order
    logic [DATA_WIDTH-1:0]   exp_val [REG_NUM];  // expected report of the writer in flight
    logic [REG_ADDR_LEN-1:0] src1_of [REG_NUM], src2_of [REG_NUM];
    int                      seq_of [REG_NUM], src_use [REG_NUM];  // readers still pending
    bit                      dst_busy [REG_NUM];
    logic [REG_ADDR_LEN-1:0] rot = '0, last_dst = '0;  // rot walks the destination pool
    int                      seq = 0, next_seq = 0, inflight = 0, accepted = 0;
    int                      results = 0, errors = 0, prop_fails = 0;
    bit                      rand_issue = 1'b0, order_check = 1'b0;

    ooo_core #(.NUM_ENTRIES(4), .FIFO_DEPTH(4)) ooo_core_i (
        .clk(clk), .reset(reset), .disp_valid(disp_valid), .func(func), .dst(dst),
        .inp1(inp1), .inp2(inp2), .issue(issue), .disp_full(disp_full),
        .result_valid(result_valid), .result_dst(result_dst), .result_data(result_data)
    );

    always #10 clk = ~clk;

    // right-shifting galois lfsr with taps 32 22 2 1, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] alu_model(input logic [2:0] f, input logic [31:0] a,
                                              input logic [31:0] b);
        case (f)
            ALU_ADD: return a + b;
            ALU_SUB: return a - b;
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_XOR: return a ^ b;
            ALU_SLL: return a << b[4:0];
            ALU_SRL: return a >> b[4:0];
            ALU_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: return 32'd0;
        endcase
    endfunction

    // r0 and a read of its own destination never wait on an older writer
    function automatic bit src_settled(input logic [4:0] s, input logic [4:0] d);
        return (s == 5'd0) || (s == d) || !dst_busy[s];
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] want,
                                   input logic [31:0] got);
        errors++;
        $display("ERR %0t %s expected %0h got %0h", $time, name, want, got);
    endtask

    task automatic report_problem(input string what);
        errors++;
        $display("%0t %s", $time, what);
    endtask

    // inputs change 1 ns after the rising edge, issue may follow the lfsr
    task automatic step_cycle();
        @(posedge clk);
        #1;
        if (rand_issue) issue = (rand_bits(2) != 32'd0);  // issue high three cycles in four
    endtask

    task automatic send(input logic [2:0] f, input logic [4:0] d, input logic [4:0] a,
                        input logic [4:0] b);
        int n;
        func = f;
        dst = d;
        inp1 = a;
        inp2 = b;
        disp_valid = 1'b1;
        for (n = 0; n < LIMIT && disp_full; n++) step_cycle();  // disp_full is stable here
        if (disp_full) begin
            report_problem("dispatch buffer stayed full and never took the instruction");
        end else begin
            exp_val[d] = alu_model(f, shadow[a], shadow[b]);  // old values, even when a is d
            if (d != 5'd0) shadow[d] = exp_val[d];
            dst_busy[d] = 1'b1;
            src1_of[d] = a;
            src2_of[d] = b;
            src_use[a]++;
            src_use[b]++;
            seq_of[d] = seq;
            seq++;
            inflight++;
            accepted++;
        end
        step_cycle();  // the accepting edge
        disp_valid = 1'b0;
    endtask

    // destination is free of writers and readers in flight, sources lean on the last one
    task automatic send_random(input bit indep);
        logic [4:0] d, a, b;
        int tries;
        d = rot;
        for (tries = 0; tries < REG_NUM && (dst_busy[d] || src_use[d] != 0); tries++) begin
            rot = rot + 1'b1;
            d = rot;
        end
        rot = rot + 1'b1;
        a = rand_bits(1) ? last_dst : 5'(rand_bits(5));  // builds dependent chains
        b = 5'(rand_bits(5));
        for (tries = 0; indep && tries < 64 && (dst_busy[a] || dst_busy[b]); tries++) begin
            a = 5'(rand_bits(5));
            b = 5'(rand_bits(5));
        end
        send(3'(rand_bits(3)), d, a, b);
        last_dst = d;
    endtask

    task automatic wait_drain();
        int n;
        rand_issue = 1'b0;
        issue = 1'b1;
        for (n = 0; n < LIMIT && inflight != 0; n++) step_cycle();
        if (inflight != 0) report_problem("results still missing after the timeout");
        repeat (4) step_cycle();  // room for a stray or repeated result to show up
    endtask

    always @(negedge clk) begin
        if (reset) begin
            assert (!result_valid) else report_problem("result_valid high during reset");
        end else if (result_valid) begin
            assert (dst_busy[result_dst])
                else report_problem($sformatf("result for r%0d that was not pending", result_dst));
            if (dst_busy[result_dst]) begin
                assert (result_data == exp_val[result_dst])
                    else report_mismatch("result_data", exp_val[result_dst], result_data);
                assert (src_settled(src1_of[result_dst], result_dst)
                        && src_settled(src2_of[result_dst], result_dst))
                    else report_problem("consumer reported before its producer");
                if (order_check) begin  // only independent ready entries are in flight then
                    assert (seq_of[result_dst] == next_seq)
                        else report_mismatch("dispatch order", next_seq, seq_of[result_dst]);
                    next_seq = seq_of[result_dst] + 1;
                end
                dst_busy[result_dst] = 1'b0;
                src_use[src1_of[result_dst]]--;
                src_use[src2_of[result_dst]]--;
                inflight--;
                results++;
            end
        end
    end

    initial begin
        int n;
        for (int r = 0; r < REG_NUM; r++) begin
            shadow[r] = DATA_WIDTH'(r);  // register r starts out holding r
            dst_busy[r] = 1'b0;
            src_use[r] = 0;
        end
        repeat (8) @(posedge clk);
        #1 reset = 1'b0;

        // issue stays low, so nothing may come out and three entries fit easily
        repeat (3) send_random(1'b0);
        for (n = 0; n < 10; n++) begin
            step_cycle();
            assert (!result_valid && !disp_full) else report_problem("activity while issue low");
        end

        // fill buffer and queue until back-pressure, then drain every accepted entry
        while (!disp_full && accepted < 2 * CAPACITY) send_random(1'b0);
        assert (accepted == CAPACITY) else report_mismatch("accepted", CAPACITY, accepted);
        wait_drain();
        assert (results == accepted) else report_mismatch("result count", accepted, results);

        // random traffic with random issue gaps
        rand_issue = 1'b1;
        for (n = 0; n < 80; n++) begin
            send_random(1'b0);
            repeat (rand_bits(2)) step_cycle();
        end
        wait_drain();

        // a write to r0 is reported as computed, the reader behind it still sees zero
        send(ALU_ADD, 5'd0, 5'd3, 5'd4);
        send(ALU_ADD, 5'd20, 5'd0, 5'd5);
        wait_drain();

        // two entries go in and the older one leaves, so the next entry lands in the
        // lower free slot while being younger than the one still waiting
        issue = 1'b0;
        next_seq = seq;
        order_check = 1'b1;
        repeat (2) send_random(1'b1);
        for (n = 0; n < LIMIT && ooo_core_i.issue_queue_i.occupancy != 2; n++) step_cycle();
        assert (ooo_core_i.issue_queue_i.occupancy == 2)
            else report_problem("first two entries never reached the queue");
        issue = 1'b1;
        step_cycle();
        issue = 1'b0;

        // four independent entries wait in a full queue, then leave oldest first
        repeat (3) send_random(1'b1);
        for (n = 0; n < LIMIT && !ooo_core_i.is_full; n++) step_cycle();
        assert (ooo_core_i.is_full) else report_problem("issue queue never filled up");
        wait_drain();
        order_check = 1'b0;

        // one ready entry, then a single issue edge and the result two edges later
        issue = 1'b0;
        send_random(1'b1);
        for (n = 0; n < LIMIT && !ooo_core_i.load; n++) step_cycle();
        assert (ooo_core_i.load) else report_problem("instruction never loaded into the queue");
        step_cycle();  // entry is valid from this edge on
        issue = 1'b1;
        step_cycle();
        issue = 1'b0;
        @(negedge clk);
        assert (!result_valid) else report_problem("result came one edge after the issue edge");
        @(negedge clk);
        assert (result_valid) else report_problem("no result two edges after the issue edge");
        wait_drain();

        prop_fails = ooo_core_i.issue_queue_i.ooo_core_props_i.fail_count;
        $display("results %0d, errors %0d, assertion failures %0d", results, errors, prop_fails);
        if (errors == 0 && prop_fails == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end
endmodule

`default_nettype wire

/* sim.f */
rtl/ooo_pkg.sv
rtl/dispatch_buffer.sv
rtl/age_select.sv
rtl/issue_queue.sv
rtl/reg_file.sv
rtl/alu_exec.sv
rtl/ooo_core.sv
tb/ooo_core_props.sv
tb/ooo_core_tb.sv
